// ==== source/wbuf_pkg.sv ====
package wbuf_pkg;

	// ==============================
	// bus and store field widths
	// ==============================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;
	localparam int ID_W = 4;

	// number of stores the buffer can hold at once
	localparam int WB_DEPTH = 4;
	// the write pointer counts 0 to WB_DEPTH, so it needs one more bit than an index
	localparam int WB_PTR_W = $clog2(WB_DEPTH + 1);
	localparam int WB_IDX_W = $clog2(WB_DEPTH);

	// ==============================
	// fault codes
	// ==============================

	localparam int FAULT_W = 2;
	localparam logic [FAULT_W-1:0] FLT_NONE = 2'd0;
	localparam logic [FAULT_W-1:0] FLT_BUS = 2'd1;
	localparam logic [FAULT_W-1:0] FLT_TLB = 2'd2;
	localparam logic [FAULT_W-1:0] FLT_WRV = 2'd3;

	// ==============================
	// bus master state encodings
	// ==============================

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BEAT1_ACK = 2'd1;
	localparam logic [1:0] ST_BEAT2_REQ = 2'd2;
	localparam logic [1:0] ST_BEAT2_ACK = 2'd3;

endpackage

// ==== source/store_port_if.sv ====
`timescale 1ns/1ps

// one store port from the issue logic into the write buffer queue
interface store_port_if import wbuf_pkg::*; ();

	// request side, held stable by the source until ack
	logic              wr;
	logic [ID_W-1:0]   id;
	logic [SEL_W-1:0]  sel;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat;

	// ack is a single cycle pulse in the cycle after the queue took the store
	logic              ack;
	// hit is combinational and tells the load path a queued store covers this word
	logic              hit;

	// the issue side drives the store and watches for ack
	modport src (
		output wr, id, sel, adr, dat,
		input  ack, hit
	);

	// the queue side takes the store and answers ack and hit
	modport sink (
		input  wr, id, sel, adr, dat,
		output ack, hit
	);

endinterface

// ==== source/store_head_if.sv ====
`timescale 1ns/1ps

// oldest queued store handed to the bus master, plus the master's requests back
interface store_head_if import wbuf_pkg::*; ();

	// head entry of the queue, only meaningful while valid is high
	logic              valid;
	logic [ID_W-1:0]   id;
	logic [SEL_W-1:0]  sel;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat;

	// retire drops the head after a good store
	logic              retire;
	// flush throws away every queued store after a fault
	logic              flush;

	modport queue (
		output valid, id, sel, adr, dat,
		input  retire, flush
	);

	// the master only reads the head and pulses retire or flush
	modport master (
		input  valid, id, sel, adr, dat,
		output retire, flush
	);

endinterface

// ==== source/store_queue.sv ====
`timescale 1ns/1ps

module store_queue import wbuf_pkg::*; (
	input logic          clk_i,
	input logic          rst_i,
	input logic          wb_en_i,
	store_port_if.sink   p0,
	store_port_if.sink   p1,
	store_head_if.queue  head
);

	// ==============================
	// queue storage
	// ==============================

	// entry 0 is always the oldest store, later arrivals sit above it
	logic [WB_DEPTH-1:0] ent_v;
	logic [ID_W-1:0]     ent_id  [WB_DEPTH];
	logic [SEL_W-1:0]    ent_sel [WB_DEPTH];
	logic [ADDR_W-1:0]   ent_adr [WB_DEPTH];
	logic [DATA_W-1:0]   ent_dat [WB_DEPTH];

	// next free slot, equal to WB_DEPTH when the queue is full
	logic [WB_PTR_W-1:0] wr_ptr;
	logic [WB_IDX_W-1:0] wr_idx;
	logic                room;
	// cleared by a fault flush and set again by the enable pulse
	logic                en_q;

	logic                p0_ack_q;
	logic                p1_ack_q;
	logic                p0_hit;
	logic                p1_hit;

	logic                take_p0;
	logic                take_p1;
	logic                do_write;
	logic                do_shift;

	logic [ID_W-1:0]     in_id;
	logic [SEL_W-1:0]    in_sel;
	logic [ADDR_W-1:0]   in_adr;
	logic [DATA_W-1:0]   in_dat;

	// ==============================
	// port arbitration
	// ==============================

	assign room = wr_ptr < WB_PTR_W'(WB_DEPTH);
	assign wr_idx = wr_ptr[WB_IDX_W-1:0];

	// a port whose ack is high is finishing its handshake, so its wr is ignored
	// and the other port may take the slot in that same cycle
	assign take_p0 = en_q & room & ~head.flush & p0.wr & ~p0_ack_q;
	assign take_p1 = en_q & room & ~head.flush & ~take_p0 & p1.wr & ~p1_ack_q;
	assign do_write = take_p0 | take_p1;

	// port 0 always wins the mux when it is taken
	assign in_id  = take_p0 ? p0.id  : p1.id;
	assign in_sel = take_p0 ? p0.sel : p1.sel;
	assign in_adr = take_p0 ? p0.adr : p1.adr;
	assign in_dat = take_p0 ? p0.dat : p1.dat;

	// an empty head slot is closed up whenever no store is written in that cycle
	assign do_shift = ~ent_v[0] & ~do_write;

	// ==============================
	// control state
	// ==============================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ent_v <= '0;
			wr_ptr <= '0;
			en_q <= 1'b1;
			p0_ack_q <= 1'b0;
			p1_ack_q <= 1'b0;
		end else begin
			p0_ack_q <= take_p0;
			p1_ack_q <= take_p1;
			if (head.flush) begin
				// a faulted store poisons everything behind it
				ent_v <= '0;
				wr_ptr <= '0;
				en_q <= 1'b0;
			end else begin
				if (wb_en_i)
					en_q <= 1'b1;
				// the retired slot stays in place until the next shift
				if (head.retire)
					ent_v[0] <= 1'b0;
				if (do_write) begin
					ent_v[wr_idx] <= 1'b1;
					wr_ptr <= wr_ptr + 1'b1;
				end else if (do_shift) begin
					ent_v <= {1'b0, ent_v[WB_DEPTH-1:1]};
					if (wr_ptr != '0)
						wr_ptr <= wr_ptr - 1'b1;
				end
			end
		end
	end

	// store payload follows the valid bits but needs no reset
	always_ff @(posedge clk_i) begin
		if (do_write) begin
			ent_id[wr_idx] <= in_id;
			ent_sel[wr_idx] <= in_sel;
			ent_adr[wr_idx] <= in_adr;
			ent_dat[wr_idx] <= in_dat;
		end else if (do_shift) begin
			for (int j = 0; j < WB_DEPTH - 1; j++) begin
				ent_id[j] <= ent_id[j+1];
				ent_sel[j] <= ent_sel[j+1];
				ent_adr[j] <= ent_adr[j+1];
				ent_dat[j] <= ent_dat[j+1];
			end
		end
	end

	// ==============================
	// load hit detection
	// ==============================

	// a load must wait while any queued store touches the same 32-bit word
	always_comb begin
		p0_hit = 1'b0;
		p1_hit = 1'b0;
		for (int n = 0; n < WB_DEPTH; n++) begin
			if (ent_v[n] && ent_adr[n][ADDR_W-1:2] == p0.adr[ADDR_W-1:2])
				p0_hit = 1'b1;
			if (ent_v[n] && ent_adr[n][ADDR_W-1:2] == p1.adr[ADDR_W-1:2])
				p1_hit = 1'b1;
		end
	end

	assign p0.ack = p0_ack_q;
	assign p1.ack = p1_ack_q;
	assign p0.hit = p0_hit;
	assign p1.hit = p1_hit;

	// the master always sees the oldest entry
	assign head.valid = ent_v[0];
	assign head.id = ent_id[0];
	assign head.sel = ent_sel[0];
	assign head.adr = ent_adr[0];
	assign head.dat = ent_dat[0];

endmodule

// ==== source/store_bus_master.sv ====
`timescale 1ns/1ps

module store_bus_master import wbuf_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               cyc_pending_i,
	input  logic               ack_i,
	input  logic               err_i,
	input  logic               tlbmiss_i,
	input  logic               wrv_i,
	store_head_if.master       head,
	output logic               cyc_o,
	output logic               stb_o,
	output logic               we_o,
	output logic [SEL_W-1:0]   sel_o,
	output logic [ADDR_W-1:0]  adr_o,
	output logic [DATA_W-1:0]  dat_o,
	output logic               wb_has_bus_o,
	output logic               commit_o,
	output logic [ID_W-1:0]    commit_id_o,
	output logic               cache_wr_o,
	output logic [SEL_W-1:0]   cache_sel_o,
	output logic [ADDR_W-1:0]  cache_adr_o,
	output logic [DATA_W-1:0]  cache_dat_o,
	output logic [FAULT_W-1:0] fault_o
);

	logic [1:0]          state;

	// upper lanes of a store that straddles a word, sent on the second beat
	logic [SEL_W-1:0]    sel_shift;
	logic [DATA_W-1:0]   dat_shift;

	// head store shifted into an 8-lane window by its byte offset
	logic [1:0]          byte_off;
	logic [2*SEL_W-1:0]  sel_win;
	logic [2*DATA_W-1:0] dat_win;

	logic                retire_q;
	logic                flush_q;

	logic                term;
	logic                fault_hit;
	logic [FAULT_W-1:0]  fault_code;
	logic                start;
	logic                beat2;
	logic                finish;

	// ==============================
	// lane steering
	// ==============================

	assign byte_off = head.adr[1:0];
	assign sel_win = {{SEL_W{1'b0}}, head.sel} << byte_off;
	assign dat_win = {{DATA_W{1'b0}}, head.dat} << {byte_off, 3'b000};

	// any of these ends the current beat
	assign term = ack_i | err_i | tlbmiss_i | wrv_i;
	assign fault_hit = err_i | tlbmiss_i | wrv_i;

	// tlb miss outranks a write violation, which outranks a plain bus error
	always_comb begin
		if (tlbmiss_i)
			fault_code = FLT_TLB;
		else if (wrv_i)
			fault_code = FLT_WRV;
		else if (err_i)
			fault_code = FLT_BUS;
		else
			fault_code = FLT_NONE;
	end

	// while retire or flush is out the queue has not yet dropped the old head,
	// so a new store must not start off it
	assign start = (state == ST_IDLE) & head.valid & ~cyc_o & ~cyc_pending_i
		& ~retire_q & ~flush_q;
	// the slave must drop its ack before the second strobe goes out
	assign beat2 = (state == ST_BEAT2_REQ) & ~ack_i;
	// a fault on the first beat ends the store without a second beat
	assign finish = ((state == ST_BEAT1_ACK) & term & (fault_hit | (sel_shift == '0)))
		| ((state == ST_BEAT2_ACK) & term);

	// ==============================
	// bus state machine
	// ==============================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= ST_IDLE;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			we_o <= 1'b0;
			wb_has_bus_o <= 1'b0;
			commit_o <= 1'b0;
			cache_wr_o <= 1'b0;
			retire_q <= 1'b0;
			flush_q <= 1'b0;
			fault_o <= FLT_NONE;
		end else begin
			// completion side effects are all single cycle pulses
			commit_o <= finish;
			cache_wr_o <= finish;
			retire_q <= finish & ~fault_hit;
			flush_q <= finish & fault_hit;
			case (state)
				ST_IDLE: begin
					if (start) begin
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o <= 1'b1;
						wb_has_bus_o <= 1'b1;
						state <= ST_BEAT1_ACK;
					end
				end
				ST_BEAT1_ACK: begin
					if (term) begin
						stb_o <= 1'b0;
						state <= finish ? ST_IDLE : ST_BEAT2_REQ;
					end
				end
				ST_BEAT2_REQ: begin
					if (beat2) begin
						stb_o <= 1'b1;
						state <= ST_BEAT2_ACK;
					end
				end
				ST_BEAT2_ACK: begin
					if (term) begin
						stb_o <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
			// a clean finish clears any older code, a faulted one records it
			if (finish) begin
				cyc_o <= 1'b0;
				we_o <= 1'b0;
				wb_has_bus_o <= 1'b0;
				fault_o <= fault_code;
			end
		end
	end

	// bus payload and the commit record carry no reset
	always_ff @(posedge clk_i) begin
		if (start) begin
			sel_o <= sel_win[SEL_W-1:0];
			adr_o <= {head.adr[ADDR_W-1:2], 2'b00};
			dat_o <= dat_win[DATA_W-1:0];
			sel_shift <= sel_win[2*SEL_W-1:SEL_W];
			dat_shift <= dat_win[2*DATA_W-1:DATA_W];
		end
		if (beat2) begin
			sel_o <= sel_shift;
			adr_o <= {adr_o[ADDR_W-1:2] + 1'b1, 2'b00};
			dat_o <= dat_shift;
			sel_shift <= '0;
		end
		// the cache gets the store as issued, not the lane-shifted form
		if (finish) begin
			commit_id_o <= head.id;
			cache_sel_o <= head.sel;
			cache_adr_o <= head.adr;
			cache_dat_o <= head.dat;
		end
	end

	assign head.retire = retire_q;
	assign head.flush = flush_q;

endmodule

// ==== source/write_buffer_top.sv ====
`timescale 1ns/1ps

module write_buffer_top import wbuf_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               wb_en_i,
	input  logic               cyc_pending_i,
	// store port 0, the higher priority one
	input  logic               p0_wr_i,
	input  logic [ID_W-1:0]    p0_id_i,
	input  logic [SEL_W-1:0]   p0_sel_i,
	input  logic [ADDR_W-1:0]  p0_adr_i,
	input  logic [DATA_W-1:0]  p0_dat_i,
	output logic               p0_ack_o,
	output logic               p0_hit_o,
	// store port 1
	input  logic               p1_wr_i,
	input  logic [ID_W-1:0]    p1_id_i,
	input  logic [SEL_W-1:0]   p1_sel_i,
	input  logic [ADDR_W-1:0]  p1_adr_i,
	input  logic [DATA_W-1:0]  p1_dat_i,
	output logic               p1_ack_o,
	output logic               p1_hit_o,
	// data bus
	output logic               cyc_o,
	output logic               stb_o,
	output logic               we_o,
	output logic [SEL_W-1:0]   sel_o,
	output logic [ADDR_W-1:0]  adr_o,
	output logic [DATA_W-1:0]  dat_o,
	input  logic               ack_i,
	input  logic               err_i,
	input  logic               tlbmiss_i,
	input  logic               wrv_i,
	// completion to the instruction queue and the data cache
	output logic               wb_has_bus_o,
	output logic               commit_o,
	output logic [ID_W-1:0]    commit_id_o,
	output logic               cache_wr_o,
	output logic [SEL_W-1:0]   cache_sel_o,
	output logic [ADDR_W-1:0]  cache_adr_o,
	output logic [DATA_W-1:0]  cache_dat_o,
	output logic [FAULT_W-1:0] fault_o
);

	store_port_if p0_if ();
	store_port_if p1_if ();
	store_head_if head_if ();

	// ==============================
	// plain ports onto the interfaces
	// ==============================

	assign p0_if.wr = p0_wr_i;
	assign p0_if.id = p0_id_i;
	assign p0_if.sel = p0_sel_i;
	assign p0_if.adr = p0_adr_i;
	assign p0_if.dat = p0_dat_i;
	assign p0_ack_o = p0_if.ack;
	assign p0_hit_o = p0_if.hit;

	assign p1_if.wr = p1_wr_i;
	assign p1_if.id = p1_id_i;
	assign p1_if.sel = p1_sel_i;
	assign p1_if.adr = p1_adr_i;
	assign p1_if.dat = p1_dat_i;
	assign p1_ack_o = p1_if.ack;
	assign p1_hit_o = p1_if.hit;

	// queue owns ordering and hits, the master owns the bus
	store_queue u_store_queue (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.wb_en_i (wb_en_i),
		.p0      (p0_if.sink),
		.p1      (p1_if.sink),
		.head    (head_if.queue)
	);

	store_bus_master u_store_bus_master (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cyc_pending_i (cyc_pending_i),
		.ack_i         (ack_i),
		.err_i         (err_i),
		.tlbmiss_i     (tlbmiss_i),
		.wrv_i         (wrv_i),
		.head          (head_if.master),
		.cyc_o         (cyc_o),
		.stb_o         (stb_o),
		.we_o          (we_o),
		.sel_o         (sel_o),
		.adr_o         (adr_o),
		.dat_o         (dat_o),
		.wb_has_bus_o  (wb_has_bus_o),
		.commit_o      (commit_o),
		.commit_id_o   (commit_id_o),
		.cache_wr_o    (cache_wr_o),
		.cache_sel_o   (cache_sel_o),
		.cache_adr_o   (cache_adr_o),
		.cache_dat_o   (cache_dat_o),
		.fault_o       (fault_o)
	);

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

// free running 100 ns clock with reset held over the first two rising edges
module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// reset is released on a falling edge so the DUT sees a clean first cycle
	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// ==== testbench/tb_bus_slave.sv ====
`timescale 1ns/1ps

// bus slave model with a programmable ack delay and faults chosen by address
module tb_bus_slave (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	input  logic [7:0]  delay_i,
	output logic        ack_o,
	output logic        err_o,
	output logic        tlbmiss_o,
	output logic        wrv_o,
	// one pulse per terminated beat, carrying what the master put on the bus
	output logic        beat_o,
	output logic [3:0]  beat_sel_o,
	output logic [31:0] beat_adr_o,
	output logic [31:0] beat_dat_o
);

	logic [7:0] wait_cnt;
	logic       resp;

	// a response is only one cycle long, and no new one starts while it is out
	assign resp = ack_o | err_o | tlbmiss_o | wrv_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			tlbmiss_o <= 1'b0;
			wrv_o <= 1'b0;
			beat_o <= 1'b0;
			beat_sel_o <= '0;
			beat_adr_o <= '0;
			beat_dat_o <= '0;
			wait_cnt <= '0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			tlbmiss_o <= 1'b0;
			wrv_o <= 1'b0;
			beat_o <= 1'b0;
			if (cyc_i && stb_i && !resp) begin
				if (wait_cnt == delay_i) begin
					wait_cnt <= '0;
					beat_o <= 1'b1;
					beat_sel_o <= sel_i;
					beat_adr_o <= adr_i;
					beat_dat_o <= dat_i;
					// the highest region wins, as the address map nests downward
					if (adr_i >= 32'hE000_0000)
						tlbmiss_o <= 1'b1;
					else if (adr_i >= 32'hD000_0000)
						wrv_o <= 1'b1;
					else if (adr_i >= 32'hC000_0000)
						err_o <= 1'b1;
					else
						ack_o <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt + 8'd1;
				end
			end
		end
	end

endmodule

// ==== testbench/write_buffer_properties.sv ====
`timescale 1ns/1ps

// bus and completion rules of the store bus master
module write_buffer_properties (
	input logic clk_i,
	input logic rst_i,
	input logic cyc_o,
	input logic stb_o,
	input logic we_o,
	input logic commit_o,
	input logic cache_wr_o
);

	// a strobe is only legal inside a bus cycle
	stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_o |-> cyc_o)
		else $error("stb_o is high outside a bus cycle");

	// each store commits in exactly one cycle
	commit_pulse: assert property (@(posedge clk_i) disable iff (rst_i) commit_o |=> !commit_o)
		else $error("commit_o stayed high for more than one cycle");

	// the cache update travels with the commit
	cache_with_commit: assert property (@(posedge clk_i) disable iff (rst_i)
		cache_wr_o == commit_o)
		else $error("cache_wr_o and commit_o disagree");

	// the bus is quiet right after reset
	quiet_after_reset: assert property (@(posedge clk_i) rst_i |=> !cyc_o && !stb_o && !we_o)
		else $error("bus active in the cycle after reset");

endmodule

bind store_bus_master write_buffer_properties u_write_buffer_properties (
	.clk_i      (clk_i),
	.rst_i      (rst_i),
	.cyc_o      (cyc_o),
	.stb_o      (stb_o),
	.we_o       (we_o),
	.commit_o   (commit_o),
	.cache_wr_o (cache_wr_o)
);

// ==== testbench/write_buffer_tb.sv ====
`timescale 1ns/1ps

module write_buffer_tb import wbuf_pkg::*; ();

	// one stimulus row, with flags that say how it is presented
	typedef struct packed {
		logic         port;
		logic [3:0]   id;
		logic [3:0]   sel;
		logic [31:0]  adr;
		logic [31:0]  dat;
		logic [7:0]   delay;
		logic [1:0]   fault;
		logic         pair;
		logic         drain;
		logic         stall;
		logic         en;
		logic         lost;
	} row_t;

	typedef struct packed {
		logic [3:0]   sel;
		logic [31:0]  adr;
		logic [31:0]  dat;
	} beat_t;

	logic clk, rst;
	logic wb_en, cyc_pending;
	logic p0_wr, p1_wr, p0_ack, p1_ack, p0_hit, p1_hit;
	logic [3:0] p0_id, p1_id, p0_sel, p1_sel;
	logic [31:0] p0_adr, p1_adr, p0_dat, p1_dat;
	logic cyc, stb, we, ack, err, tlbmiss, wrv;
	logic [3:0] sel;
	logic [31:0] adr, dat;
	logic has_bus, commit, cache_wr;
	logic [3:0] commit_id, cache_sel;
	logic [31:0] cache_adr, cache_dat;
	logic [1:0] fault;
	logic [7:0] slave_delay;
	logic beat;
	logic [3:0] beat_sel;
	logic [31:0] beat_adr, beat_dat;

	row_t rows[$];
	row_t exp_commits[$];
	beat_t exp_beats[$];
	row_t got_row;
	beat_t got_beat;
	int commit_cnt = 0;
	int cycles = 0;
	int limit = 1000000;
	int idx;

	tb_clock_gen u_clock_gen (.clk_o(clk), .rst_o(rst));

	tb_bus_slave u_bus_slave (
		.clk_i(clk), .rst_i(rst), .cyc_i(cyc), .stb_i(stb), .sel_i(sel),
		.adr_i(adr), .dat_i(dat), .delay_i(slave_delay),
		.ack_o(ack), .err_o(err), .tlbmiss_o(tlbmiss), .wrv_o(wrv),
		.beat_o(beat), .beat_sel_o(beat_sel), .beat_adr_o(beat_adr), .beat_dat_o(beat_dat)
	);

	write_buffer_top u_write_buffer_top (
		.clk_i(clk), .rst_i(rst), .wb_en_i(wb_en), .cyc_pending_i(cyc_pending),
		.p0_wr_i(p0_wr), .p0_id_i(p0_id), .p0_sel_i(p0_sel), .p0_adr_i(p0_adr),
		.p0_dat_i(p0_dat), .p0_ack_o(p0_ack), .p0_hit_o(p0_hit),
		.p1_wr_i(p1_wr), .p1_id_i(p1_id), .p1_sel_i(p1_sel), .p1_adr_i(p1_adr),
		.p1_dat_i(p1_dat), .p1_ack_o(p1_ack), .p1_hit_o(p1_hit),
		.cyc_o(cyc), .stb_o(stb), .we_o(we), .sel_o(sel), .adr_o(adr), .dat_o(dat),
		.ack_i(ack), .err_i(err), .tlbmiss_i(tlbmiss), .wrv_i(wrv),
		.wb_has_bus_o(has_bus), .commit_o(commit), .commit_id_o(commit_id),
		.cache_wr_o(cache_wr), .cache_sel_o(cache_sel), .cache_adr_o(cache_adr),
		.cache_dat_o(cache_dat), .fault_o(fault)
	);

	// ==============================
	// failure reporting
	// ==============================

	task automatic stop_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
			else stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	// ==============================
	// table and expected values
	// ==============================

	task automatic add_row(input logic port, input logic [3:0] id, input logic [3:0] sel_v,
		input logic [31:0] adr_v, input logic [7:0] delay, input logic [1:0] flt,
		input logic pair, input logic drain, input logic stall, input logic en,
		input logic lost);
		row_t r;
		r = '{port, id, sel_v, adr_v, $urandom(), delay, flt, pair, drain, stall, en, lost};
		rows.push_back(r);
	endtask

	// each byte k of the store moves to lane k plus the byte offset of the address
	task automatic expect_store(input row_t r);
		logic [7:0] lane_sel;
		logic [63:0] lane_dat;
		int off;
		if (!r.lost) begin
			off = int'(r.adr[1:0]);
			lane_sel = '0;
			lane_dat = '0;
			for (int k = 0; k < 4; k++) begin
				lane_sel[k + off] = r.sel[k];
				lane_dat[(k + off) * 8 +: 8] = r.dat[k * 8 +: 8];
			end
			exp_commits.push_back(r);
			exp_beats.push_back('{lane_sel[3:0], {r.adr[31:2], 2'b00}, lane_dat[31:0]});
			// a faulted beat ends the store, so no upper lanes follow it
			if (lane_sel[7:4] != 4'h0 && r.fault == FLT_NONE)
				exp_beats.push_back('{lane_sel[7:4], {r.adr[31:2], 2'b00} + 32'd4,
					lane_dat[63:32]});
		end
	endtask

	// ==============================
	// port driving
	// ==============================

	task automatic drive_port(input row_t r);
		if (r.port == 1'b0) begin
			p0_wr = 1'b1;
			p0_id = r.id;
			p0_sel = r.sel;
			p0_adr = r.adr;
			p0_dat = r.dat;
		end else begin
			p1_wr = 1'b1;
			p1_id = r.id;
			p1_sel = r.sel;
			p1_adr = r.adr;
			p1_dat = r.dat;
		end
	endtask

	task automatic send_one(input row_t r);
		int seen;
		seen = commit_cnt;
		drive_port(r);
		do @(negedge clk); while (!(r.port ? p1_ack : p0_ack));
		if (r.port)
			p1_wr = 1'b0;
		else
			p0_wr = 1'b0;
		// a full queue may only take this store once the head has committed
		if (r.stall)
			assert (commit_cnt > seen)
				else stop_run("a store was accepted while the queue was full");
		expect_store(r);
	endtask

	// both ports ask in the same cycle and port 0 must be taken first
	task automatic send_pair(input row_t a, input row_t b);
		logic got_a;
		logic got_b;
		got_a = 1'b0;
		got_b = 1'b0;
		drive_port(a);
		drive_port(b);
		while (!(got_a && got_b)) begin
			@(negedge clk);
			if (p1_ack && !got_b) begin
				assert (got_a) else stop_run("port 1 was accepted before port 0");
				got_b = 1'b1;
				p1_wr = 1'b0;
				expect_store(b);
			end
			if (p0_ack && !got_a) begin
				got_a = 1'b1;
				p0_wr = 1'b0;
				expect_store(a);
			end
		end
	endtask

	// two extra cycles let a flush after the last commit settle
	task automatic wait_drain();
		while (exp_commits.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	// the hit flag is combinational, so it is probed between clock edges
	// both ports are idle here, so their addresses are free to move
	task automatic probe_hits(input logic [31:0] queued_adr);
		p0_adr = queued_adr ^ 32'h3;
		p1_adr = queued_adr + 32'h100;
		#10;
		check_value("p0_hit_o", 32'(p0_hit), 32'h1);
		check_value("p1_hit_o", 32'(p1_hit), 32'h0);
		@(negedge clk);
		p0_adr = queued_adr + 32'h100;
		p1_adr = queued_adr ^ 32'h3;
		#10;
		check_value("p0_hit_o", 32'(p0_hit), 32'h0);
		check_value("p1_hit_o", 32'(p1_hit), 32'h1);
		@(negedge clk);
	endtask

	// ==============================
	// monitors and timeout
	// ==============================

	always @(negedge clk) begin
		if (!rst && beat) begin
			assert (exp_beats.size() != 0)
				else stop_run("a bus beat appeared that no accepted store explains");
			got_beat = exp_beats.pop_front();
			check_value("sel_o", 32'(beat_sel), 32'(got_beat.sel));
			check_value("adr_o", beat_adr, got_beat.adr);
			check_value("dat_o", beat_dat, got_beat.dat);
		end
	end

	always @(negedge clk) begin
		if (!rst && commit) begin
			assert (exp_commits.size() != 0)
				else stop_run("a store committed that was never expected to");
			got_row = exp_commits.pop_front();
			check_value("commit_id_o", 32'(commit_id), 32'(got_row.id));
			check_value("cache_wr_o", 32'(cache_wr), 32'h1);
			check_value("cache_sel_o", 32'(cache_sel), 32'(got_row.sel));
			check_value("cache_adr_o", cache_adr, got_row.adr);
			check_value("cache_dat_o", cache_dat, got_row.dat);
			check_value("fault_o", 32'(fault), 32'(got_row.fault));
			// the final terminating edge also closes the bus cycle
			check_value("cyc_o", 32'(cyc), 32'h0);
			check_value("stb_o", 32'(stb), 32'h0);
			commit_cnt++;
		end
	end

	// we_o and the bus ownership flag rise and drop with cyc_o
	always @(negedge clk) begin
		if (!rst) begin
			check_value("wb_has_bus_o", 32'(has_bus), 32'(cyc));
			check_value("we_o", 32'(we), 32'(cyc));
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit)
			stop_run("the run timed out waiting for the write buffer");
	end

	// ==============================
	// stimulus
	// ==============================

	initial begin
		wb_en = 1'b0;
		cyc_pending = 1'b0;
		slave_delay = 8'd0;
		p0_wr = 1'b0;
		p0_id = '0;
		p0_sel = '0;
		p0_adr = '0;
		p0_dat = '0;
		p1_wr = 1'b0;
		p1_id = '0;
		p1_sel = '0;
		p1_adr = '0;
		p1_dat = '0;
		void'($urandom(5532));

		// aligned, then two stores that straddle a word boundary
		add_row(1'b0, 4'd1, 4'hF, 32'h0000_1000, 8'd0, FLT_NONE, 0, 1, 0, 0, 0);
		add_row(1'b0, 4'd2, 4'h3, 32'h0000_1003, 8'd1, FLT_NONE, 0, 1, 0, 0, 0);
		add_row(1'b1, 4'd3, 4'hF, 32'h0000_2002, 8'd2, FLT_NONE, 0, 1, 0, 0, 0);
		// both ports in the same cycle
		add_row(1'b0, 4'd4, 4'h1, 32'h0000_3000, 8'd0, FLT_NONE, 1, 0, 0, 0, 0);
		add_row(1'b1, 4'd5, 4'hC, 32'h0000_3010, 8'd0, FLT_NONE, 0, 1, 0, 0, 0);
		// slow bus fills the queue and the fifth store must wait
		add_row(1'b0, 4'd6, 4'hF, 32'h0000_0100, 8'd20, FLT_NONE, 0, 0, 0, 0, 0);
		add_row(1'b0, 4'd7, 4'h6, 32'h0000_0104, 8'd20, FLT_NONE, 0, 0, 0, 0, 0);
		add_row(1'b0, 4'd8, 4'hF, 32'h0000_0108, 8'd20, FLT_NONE, 0, 0, 0, 0, 0);
		add_row(1'b0, 4'd9, 4'h8, 32'h0000_010C, 8'd20, FLT_NONE, 0, 0, 0, 0, 0);
		add_row(1'b0, 4'd10, 4'hF, 32'h0000_0110, 8'd20, FLT_NONE, 0, 1, 1, 0, 0);
		// one fault per region, each dropping the store queued behind it
		add_row(1'b0, 4'd11, 4'hF, 32'hE000_0010, 8'd0, FLT_TLB, 1, 0, 0, 0, 0);
		add_row(1'b1, 4'd12, 4'hF, 32'h0000_4000, 8'd0, FLT_NONE, 0, 1, 0, 0, 1);
		add_row(1'b0, 4'd13, 4'h3, 32'h0000_5000, 8'd0, FLT_NONE, 0, 1, 0, 1, 0);
		add_row(1'b0, 4'd14, 4'hF, 32'hD000_0020, 8'd1, FLT_WRV, 1, 0, 0, 0, 0);
		add_row(1'b1, 4'd15, 4'hF, 32'h0000_4004, 8'd1, FLT_NONE, 0, 1, 0, 0, 1);
		add_row(1'b0, 4'd0, 4'hC, 32'h0000_6004, 8'd0, FLT_NONE, 0, 1, 0, 1, 0);
		add_row(1'b0, 4'd1, 4'hF, 32'hC000_0040, 8'd0, FLT_BUS, 1, 0, 0, 0, 0);
		add_row(1'b1, 4'd2, 4'hF, 32'h0000_4008, 8'd0, FLT_NONE, 0, 1, 0, 0, 1);
		add_row(1'b0, 4'd3, 4'h1, 32'h0000_7001, 8'd0, FLT_NONE, 0, 1, 0, 1, 0);
		limit = 60 * rows.size() + 200;

		wait (!rst);
		@(negedge clk);

		// out of reset the bus is idle, nothing is acked and no fault is held
		check_value("cyc_o", 32'(cyc), 32'h0);
		check_value("stb_o", 32'(stb), 32'h0);
		check_value("we_o", 32'(we), 32'h0);
		check_value("wb_has_bus_o", 32'(has_bus), 32'h0);
		check_value("commit_o", 32'(commit), 32'h0);
		check_value("cache_wr_o", 32'(cache_wr), 32'h0);
		check_value("p0_ack_o", 32'(p0_ack), 32'h0);
		check_value("p1_ack_o", 32'(p1_ack), 32'h0);
		check_value("p0_hit_o", 32'(p0_hit), 32'h0);
		check_value("p1_hit_o", 32'(p1_hit), 32'h0);
		check_value("fault_o", 32'(fault), 32'(FLT_NONE));

		idx = 0;
		while (idx < rows.size()) begin
			// the enable pulse reopens a queue shut by a fault
			if (rows[idx].en) begin
				wb_en = 1'b1;
				@(negedge clk);
				wb_en = 1'b0;
			end
			slave_delay = rows[idx].delay;
			if (rows[idx].stall)
				probe_hits(rows[idx - 1].adr);
			if (rows[idx].pair) begin
				send_pair(rows[idx], rows[idx + 1]);
				idx++;
			end else begin
				send_one(rows[idx]);
			end
			if (rows[idx].drain)
				wait_drain();
			idx++;
		end

		if (exp_commits.size() != 0 || exp_beats.size() != 0) begin
			stop_run("stores were still outstanding at the end of the run");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== build.f ====
source/wbuf_pkg.sv
source/store_port_if.sv
source/store_head_if.sv
source/store_queue.sv
source/store_bus_master.sv
source/write_buffer_top.sv
testbench/tb_clock_gen.sv
testbench/tb_bus_slave.sv
testbench/write_buffer_properties.sv
testbench/write_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the write buffer testbench with Verilator and run it
# the exit status is the simulator's, so a $fatal anywhere fails the script

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module write_buffer_tb \
	-o write_buffer_sim \
	&& ./obj_dir/write_buffer_sim \
	|| exit 1
